/* cipher_link.f */
hdl/cipher_pkg.sv
hdl/link_pkg.sv
hdl/vigenere_cipher.sv
hdl/lane_capture.sv
hdl/loss_monitor.sv
hdl/frame_check.sv
hdl/cipher_link_top.sv
testbench/cipher_link_assertions.sv
testbench/cipher_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the cipher link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cipher_link_tb \
    -f cipher_link.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vcipher_link_tb > sim.log 2>&1 \
    || echo "Simulator exited with an error status"

grep -q "^ALL TESTS PASSED$" sim.log \
    && { cat sim.log; echo "Simulation passed"; exit 0; } \
    || { cat sim.log; echo "Simulation failed"; exit 1; }

/* testbench/cipher_link_tb.sv */
//////////////////////////////
// Cipher link testbench
// Random frames, reference model and result checks
//////////////////////////////
`default_nettype none

module cipher_link_tb;
    import cipher_pkg::*;
    import link_pkg::*;

    localparam int NUM_TESTS    = 5;
    localparam int WATCHDOG_T   = (NUM_TESTS * 40 + 100) * 40;
    localparam int ROUND_TRIPS  = 6;
    localparam int PARTIAL_RUNS = 6;
    localparam int LOSS_CYCLES  = 8;   // One past saturation

    logic         clk;
    logic         rst_n;
    key_t         key;
    sym_block_t   plaintext;
    lane_strobe_t lane_strobe;
    logic         frame_active;
    logic         frame_start;
    sym_block_t   recovered;
    lost_count_t  lost_count;
    logic         link_failed;
    link_status_e status;

    // Reference model state
    key_t         m_key;
    sym_block_t   m_pt;
    lane_strobe_t m_mask;   // Lanes strobed since the last frame_start
    lost_count_t  m_count;

    logic         check_armed;
    sym_block_t   exp_block;
    logic         exp_failed;
    link_status_e exp_status;
    logic [31:0]  rng_state;
    string        test_name;
    int           test_errors;
    int           test_checks;
    int           pass_count;
    int           fail_count;

    cipher_link_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .key          (key),
        .plaintext    (plaintext),
        .lane_strobe  (lane_strobe),
        .frame_active (frame_active),
        .frame_start  (frame_start),
        .recovered    (recovered),
        .lost_count   (lost_count),
        .link_failed  (link_failed),
        .status       (status)
    );

    bind cipher_link_top cipher_link_assertions u_checks (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .lost_count  (lost_count),
        .link_failed (link_failed),
        .status      (status)
    );

    // Strobed lanes give back plaintext, empty lanes decrypt a zero
    function automatic sym_block_t expected_block(input sym_block_t pt, input key_t k,
                                                  input lane_strobe_t seen);
        sym_block_t blk;
        for (int i = 0; i < NUM_SYMS; i++) begin
            if (seen[i]) begin
                blk.syms[i] = pt.syms[i];
            end else begin
                blk.syms[i] = symbol_t'((8 - int'(k)) % 8);
            end
        end
        return blk;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_T);
        $display("Watchdog expired at %0t before all tests finished", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic report_value(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
        test_errors++;
        $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, expected, actual);
    endtask

    // Compare process, runs once per armed check at the falling edge
    always @(negedge clk) begin
        if (check_armed) begin
            exp_block  = expected_block(m_pt, m_key, m_mask);
            exp_failed = (int'(m_count) > DEFAULT_LOST_LIMIT);
            if (exp_failed) begin
                exp_status = LINK_FAILED;   // Failure wins even with good data
            end else if (exp_block == m_pt) begin
                exp_status = LINK_MATCH;
            end else begin
                exp_status = LINK_PENDING;
            end
            test_checks++;
            if (recovered !== exp_block) begin
                report_value("recovered", {8'h00, exp_block}, {8'h00, recovered});
            end
            if (lost_count !== m_count) begin
                report_value("lost_count", {29'h0, m_count}, {29'h0, lost_count});
            end
            if (link_failed !== exp_failed) begin
                report_value("link_failed", {31'h0, exp_failed}, {31'h0, link_failed});
            end
            if (status !== exp_status) begin
                report_value("status", {30'h0, exp_status}, {30'h0, status});
            end
            check_armed = 1'b0;
        end
    end

    task automatic apply_cycle(input lane_strobe_t strobe, input logic active,
                               input logic start);
        @(posedge clk);
        lane_strobe  <= strobe;
        frame_active <= active;
        frame_start  <= start;
        if (start) begin
            m_mask  = '0;   // Clear beats any strobe in the same cycle
            m_count = '0;
        end else begin
            m_mask = m_mask | strobe;
            if (active && (strobe == '0) && (m_count != 3'd7)) begin
                m_count = m_count + lost_count_t'(1);
            end
        end
    endtask

    task automatic begin_frame(input key_t k, input sym_block_t pt);
        @(posedge clk);
        key          <= k;
        plaintext    <= pt;
        lane_strobe  <= '0;
        frame_active <= 1'b0;
        frame_start  <= 1'b1;
        m_key   = k;
        m_pt    = pt;
        m_mask  = '0;
        m_count = '0;
    endtask

    // Quiet inputs, give status its extra edge, then hand over to the compare
    task automatic run_check();
        apply_cycle('0, 1'b0, 1'b0);
        @(posedge clk);
        check_armed = 1'b1;
        wait (check_armed == 1'b0);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("Test %-14s %s (%0d checks, %0d errors)", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
    endtask

    task automatic check_after_reset();
        start_test("after_reset");
        run_check();
        finish_test();
    endtask

    task automatic check_round_trip();
        logic [31:0] r;
        start_test("round_trip");
        for (int n = 0; n < ROUND_TRIPS; n++) begin
            draw_random(r);
            begin_frame(key_t'(r[31:29]), r[23:0]);
            apply_cycle('1, 1'b1, 1'b0);
            run_check();
        end
        finish_test();
    endtask

    task automatic check_partial_strobes();
        logic [31:0]  r;
        lane_strobe_t mask;
        start_test("partial");
        for (int n = 0; n < PARTIAL_RUNS; n++) begin
            draw_random(r);
            begin_frame(key_t'(r[26:24]), r[23:0]);
            draw_random(r);
            mask = r[7:0];
            if (mask == '0) mask = 8'h01;
            if (mask == '1) mask = 8'hfe;   // Keep at least one lane for later
            apply_cycle(mask, 1'b1, 1'b0);
            run_check();
            apply_cycle(~mask, 1'b1, 1'b0);
            run_check();
        end
        finish_test();
    endtask

    task automatic check_lost_transfers();
        logic [31:0] r;
        start_test("lost");
        draw_random(r);
        begin_frame(key_t'(r[10:8]), r[31:8]);
        apply_cycle('1, 1'b1, 1'b0);
        run_check();
        for (int k = 1; k <= LOSS_CYCLES; k++) begin
            apply_cycle('0, 1'b1, 1'b0);
            run_check();
            if (k == 2) begin
                repeat (3) apply_cycle('0, 1'b0, 1'b0);   // Idle frame adds no loss
                run_check();
            end
        end
        finish_test();
    endtask

    task automatic check_frame_clear();
        start_test("frame_clear");
        apply_cycle('1, 1'b1, 1'b1);
        run_check();
        apply_cycle('1, 1'b1, 1'b0);
        run_check();
        finish_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        key          = 3'd5;
        plaintext    = '0;
        lane_strobe  = '0;
        frame_active = 1'b0;
        frame_start  = 1'b0;
        check_armed  = 1'b0;
        rng_state    = 32'd9581;
        pass_count   = 0;
        fail_count   = 0;
        m_key        = 3'd5;
        m_pt         = '0;
        m_mask       = '0;
        m_count      = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        check_after_reset();
        check_round_trip();
        check_partial_strobes();
        check_lost_transfers();
        check_frame_clear();

        $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
                 pass_count, fail_count, dut0.u_checks.assert_errors);
        if ((fail_count == 0) && (dut0.u_checks.assert_errors == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : cipher_link_tb

`default_nettype wire

/* testbench/cipher_link_assertions.sv */
//////////////////////////////
// Cipher link assertions
// Bound checks on loss count and link status
//////////////////////////////
`default_nettype none

module cipher_link_assertions (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          frame_start,
    input wire link_pkg::lost_count_t   lost_count,
    input wire                          link_failed,
    input wire link_pkg::link_status_e  status
);
    import link_pkg::*;

    int unsigned assert_errors = 0;   // Read by the testbench at the end

    // The count only moves down when a new frame starts
    count_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(frame_start)) |-> (lost_count >= $past(lost_count)))
        else begin
            assert_errors = assert_errors + 1;
            $error("lost_count decreased without reset or frame_start");
        end

    // Status register follows the failure flag one cycle later
    failed_to_status: assert property (@(posedge clk) disable iff (!rst_n)
        link_failed |=> (status == LINK_FAILED))
        else begin
            assert_errors = assert_errors + 1;
            $error("status did not become LINK_FAILED after link_failed");
        end

    status_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(status))
        else begin
            assert_errors = assert_errors + 1;
            $error("status has unknown bits");
        end

endmodule : cipher_link_assertions

`default_nettype wire

/* hdl/cipher_link_top.sv */
//////////////////////////////
// Cipher link top
// Encrypt, lane capture, decrypt, loss monitor and status check
//////////////////////////////
`default_nettype none

module cipher_link_top #(
    parameter int LOST_LIMIT = link_pkg::DEFAULT_LOST_LIMIT
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire cipher_pkg::key_t        key,
    input  wire cipher_pkg::sym_block_t  plaintext,   // Held stable for a frame
    input  wire link_pkg::lane_strobe_t  lane_strobe,
    input  wire                          frame_active,
    input  wire                          frame_start,  // Single-cycle pulse
    output cipher_pkg::sym_block_t       recovered,
    output link_pkg::lost_count_t        lost_count,
    output logic                         link_failed,
    output link_pkg::link_status_e       status
);
    import cipher_pkg::*;

    sym_block_t cipher_block;   // Ciphertext on the sending side
    sym_block_t held_block;     // Ciphertext as captured by the lanes

    // Sending side
    vigenere_cipher #(
        .MODE (OP_ENCRYPT)
    ) u_encrypt (
        .in_block  (plaintext),
        .key       (key),
        .out_block (cipher_block)
    );

    // Lane channel
    lane_capture u_lane_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_start  (frame_start),
        .lane_strobe  (lane_strobe),
        .cipher_block (cipher_block),
        .held_block   (held_block)
    );

    // Receiving side, same key
    vigenere_cipher #(
        .MODE (OP_DECRYPT)
    ) u_decrypt (
        .in_block  (held_block),
        .key       (key),
        .out_block (recovered)
    );

    loss_monitor #(
        .LOST_LIMIT (LOST_LIMIT)
    ) u_loss_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_active (frame_active),
        .frame_start  (frame_start),
        .lane_strobe  (lane_strobe),
        .lost_count   (lost_count),
        .link_failed  (link_failed)
    );

    // Combines data match and loss result into one status
    frame_check u_frame_check (
        .clk         (clk),
        .rst_n       (rst_n),
        .recovered   (recovered),
        .plaintext   (plaintext),
        .link_failed (link_failed),
        .status      (status)
    );

endmodule : cipher_link_top

`default_nettype wire

/* hdl/frame_check.sv */
//////////////////////////////
// Frame check
// Compares recovered block to plaintext, registers link status
//////////////////////////////
`default_nettype none

module frame_check (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire cipher_pkg::sym_block_t  recovered,
    input  wire cipher_pkg::sym_block_t  plaintext,
    input  wire                          link_failed,
    output link_pkg::link_status_e       status
);
    import cipher_pkg::*;
    import link_pkg::*;

    logic [NUM_SYMS-1:0] sym_equal;   // One bit per symbol pair
    logic                block_equal;
    link_status_e        status_next;

    genvar i;

    generate
        for (i = 0; i < NUM_SYMS; i++) begin : g_cmp
            assign sym_equal[i] = (recovered.syms[i] == plaintext.syms[i]);
        end
    endgenerate

    // Whole block matches only when every lane does
    assign block_equal = &sym_equal;

    always_comb begin
        if (link_failed) begin
            status_next = LINK_FAILED;    // Failure wins over good data
        end else if (block_equal) begin
            status_next = LINK_MATCH;
        end else begin
            status_next = LINK_PENDING;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= LINK_PENDING;
        end else begin
            status <= status_next;
        end
    end

endmodule : frame_check

`default_nettype wire

/* hdl/loss_monitor.sv */
//////////////////////////////
// Loss monitor
// Counts strobe-less active cycles and flags link failure
//////////////////////////////
`default_nettype none

module loss_monitor #(
    parameter int LOST_LIMIT = link_pkg::DEFAULT_LOST_LIMIT
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          frame_active,
    input  wire                          frame_start,
    input  wire link_pkg::lane_strobe_t  lane_strobe,
    output link_pkg::lost_count_t        lost_count,
    output logic                         link_failed
);
    import link_pkg::*;

    localparam lost_count_t LOST_MAX = '1;           // Saturation point
    localparam lost_count_t LIMIT    = lost_count_t'(LOST_LIMIT);

    logic lost_cycle;

    // A frame cycle in which no lane moved any data
    assign lost_cycle = frame_active && (lane_strobe == '0);

    always_ff @(posedge clk) begin
        if (!rst_n || frame_start) begin
            lost_count <= '0;
        end else if (lost_cycle && (lost_count != LOST_MAX)) begin
            lost_count <= lost_count + lost_count_t'(1);
        end
    end

    // Failure follows the count directly, no extra register stage
    assign link_failed = (lost_count > LIMIT);

endmodule : loss_monitor

`default_nettype wire

/* hdl/lane_capture.sv */
//////////////////////////////
// Lane capture
// Strobe-gated symbol registers, one per lane
//////////////////////////////
`default_nettype none

module lane_capture (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           frame_start,
    input  wire link_pkg::lane_strobe_t   lane_strobe,
    input  wire cipher_pkg::sym_block_t   cipher_block,
    output cipher_pkg::sym_block_t        held_block
);
    import cipher_pkg::*;

    // A new frame wipes every lane, even a lane strobed in the same cycle
    logic lane_clear;

    assign lane_clear = !rst_n || frame_start;

    always_ff @(posedge clk) begin
        if (lane_clear) begin
            held_block <= '0;
        end else begin
            for (int i = 0; i < NUM_SYMS; i++) begin
                if (lane_strobe[i]) begin
                    held_block.syms[i] <= cipher_block.syms[i];   // Take this lane's symbol
                end
                // Unstrobed lanes keep what they had
            end
        end
    end

endmodule : lane_capture

`default_nettype wire

/* hdl/vigenere_cipher.sv */
//////////////////////////////
// Vigenere shift cipher
// Adds or subtracts the key on every symbol, modulo 8
//////////////////////////////
`default_nettype none

module vigenere_cipher #(
    parameter cipher_pkg::cipher_op_e MODE = cipher_pkg::OP_ENCRYPT
) (
    input  wire cipher_pkg::sym_block_t in_block,
    input  wire cipher_pkg::key_t       key,
    output cipher_pkg::sym_block_t      out_block
);
    import cipher_pkg::*;

    genvar i;

    generate
        for (i = 0; i < NUM_SYMS; i++) begin : g_sym
            // One spare bit holds the carry or borrow before masking
            logic [SYM_W:0] wide;

            if (MODE == OP_ENCRYPT) begin : g_enc
                assign wide = {1'b0, in_block.syms[i]} + {1'b0, key};
            end else begin : g_dec
                // Borrow lands in the top bit, low bits are already mod 8
                assign wide = {1'b0, in_block.syms[i]} - {1'b0, key};
            end

            // Mask off the top bit, this is the modulo-8 wrap
            assign out_block.syms[i] = wide[SYM_W-1:0];
        end
    endgenerate

endmodule : vigenere_cipher

`default_nettype wire

/* hdl/link_pkg.sv */
//////////////////////////////
// Link package
// Lane strobes, loss counter and link status
//////////////////////////////
`default_nettype none

package link_pkg;

    // One strobe per symbol lane
    typedef logic [cipher_pkg::NUM_SYMS-1:0] lane_strobe_t;

    // Lost-transfer counter, saturates at all ones
    localparam int LOST_W = 3;
    typedef logic [LOST_W-1:0] lost_count_t;

    // Link fails once the count is strictly above this
    localparam int DEFAULT_LOST_LIMIT = 4;

    typedef enum logic [1:0] {
        LINK_PENDING = 2'b00,   // Healthy, block still incomplete
        LINK_MATCH   = 2'b01,   // Healthy, recovered block equals plaintext
        LINK_FAILED  = 2'b10    // Too many lost transfers
    } link_status_e;

endpackage : link_pkg

`default_nettype wire

/* hdl/cipher_pkg.sv */
//////////////////////////////
// Cipher package
// Symbol, key and block types plus the cipher operation
//////////////////////////////
`default_nettype none

package cipher_pkg;

    // Symbols and keys share one width, arithmetic wraps at 2**SYM_W
    localparam int SYM_W    = 3;
    localparam int NUM_SYMS = 8;   // One block, one lane per symbol

    typedef logic [SYM_W-1:0] symbol_t;
    typedef logic [SYM_W-1:0] key_t;

    // Symbol 0 sits in the low bits
    typedef struct packed {
        symbol_t [NUM_SYMS-1:0] syms;
    } sym_block_t;

    // Direction of the shift cipher
    typedef enum logic {
        OP_ENCRYPT = 1'b0,   // Add key
        OP_DECRYPT = 1'b1    // Subtract key
    } cipher_op_e;

endpackage : cipher_pkg

`default_nettype wire
